// File: objbuf.f
rtl/vid_pkg.sv
rtl/obj_pkg.sv
rtl/obj_dual_ram.sv
rtl/vid_timing.sv
rtl/obj_dma_regs.sv
rtl/obj_buffer.sv
rtl/obj_sub_top.sv
testbench/obj_sub_tb.sv

// File: Makefile
# Verilator build and run for the object table subsystem

VERILATOR ?= verilator
TOP       ?= obj_sub_tb
FILELIST  ?= objbuf.f
LOG       ?= sim.log
FLAGS     ?=

OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

# Compile the testbench and RTL into one simulation binary
build:
	$(VERILATOR) --binary --timing --assert $(FLAGS) \
		-f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# Run, keep the log, fail on the failure message or a bad exit status
run: build
	./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "Checks failed" $(LOG); then \
		echo "Simulation reported failures, see $(LOG)"; exit 1; \
	fi; \
	exit $$status

lint:
	$(VERILATOR) --lint-only --timing $(FLAGS) \
		-f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: testbench/obj_sub_tb.sv
/* Object subsystem testbench
   Table-driven checks of CPU access, table copy and table readback */
module obj_sub_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import vid_pkg::*;
    import obj_pkg::*;

    // One frame in clocks, used for the wait limits
    localparam int FRAME_CLKS = V_TOTAL * H_TOTAL * PXL_DIV;

    typedef enum logic [2:0] {
        RULE_TIMING, RULE_READBACK, RULE_BYTES, RULE_NO_COPY,
        RULE_COPY_SCAN, RULE_COPY_GROUP, RULE_ONE_COPY
    } rule_t;

    typedef enum logic [1:0] {FILL_NONE, FILL_RANDOM, FILL_SAME} fill_t;

    // One row of the test table
    typedef struct packed {
        rule_t      rule;
        logic       mode;
        fill_t      fill;
        logic [1:0] dsn;
    } test_row_t;

    logic                clk = 1'b0;
    logic                rst;
    cpu_bus_t            cpu;
    obj_word_t           obj_dout;
    logic [OBJ_AW-1:0]   tbl_addr;
    obj_word_t           tbl_dout;
    vid_t                vid;

    // Expected RAM contents, both start cleared
    obj_word_t           buf_model [OBJ_DEPTH];
    obj_word_t           tbl_model [OBJ_DEPTH];

    string               test_names [$];
    test_row_t           test_rows [$];
    string               cur_name;
    bit                  test_bad;
    int                  tests_run;
    int                  tests_failed;

    obj_sub_top obj_sub_top_inst (
        .clk      (clk),
        .rst      (rst),
        .cpu      (cpu),
        .obj_dout (obj_dout),
        .tbl_addr (tbl_addr),
        .tbl_dout (tbl_dout),
        .vid      (vid)
    );

    // 10 ns clock
    always #5 clk = ~clk;

    // Bus with no select active
    function automatic cpu_bus_t bus_idle();
        cpu_bus_t b;
        b = '0;
        b.rnw = 1'b1;
        b.dsn = '1;
        return b;
    endfunction

    // A low strobe bit replaces that byte
    function automatic obj_word_t merge_bytes(obj_word_t old, obj_word_t data, logic [1:0] dsn);
        obj_word_t merged;
        merged = old;
        if (!dsn[0]) merged[7:0] = data[7:0];
        if (!dsn[1]) merged[15:8] = data[15:8];
        return merged;
    endfunction

    task automatic add_test(input string name, input rule_t rule, input logic mode,
                            input fill_t fill, input logic [1:0] dsn);
        test_row_t row;
        row = '{rule: rule, mode: mode, fill: fill, dsn: dsn};
        test_names.push_back(name);
        test_rows.push_back(row);
    endtask

    task automatic cpu_write(input logic [OBJ_AW-1:0] addr, input obj_word_t data,
                             input logic [1:0] dsn);
        cpu_bus_t b;
        b = bus_idle();
        b.addr      = addr;
        b.dout      = data;
        b.dsn       = dsn;
        b.rnw       = 1'b0;
        b.objram_cs = 1'b1;
        @(posedge clk);
        cpu <= b;
        @(posedge clk);
        cpu <= bus_idle();
        buf_model[addr] = merge_bytes(buf_model[addr], data, dsn);
    endtask

    // Data is valid one clock after the address
    task automatic cpu_read(input logic [OBJ_AW-1:0] addr, output obj_word_t data);
        cpu_bus_t b;
        b = bus_idle();
        b.addr      = addr;
        b.objram_cs = 1'b1;
        @(posedge clk);
        cpu <= b;
        @(posedge clk);
        cpu <= bus_idle();
        @(negedge clk);
        data = obj_dout;
    endtask

    task automatic reg_write(input obj_word_t data);
        cpu_bus_t b;
        b = bus_idle();
        b.dout   = data;
        b.dsn    = 2'b00;
        b.rnw    = 1'b0;
        b.reg_cs = 1'b1;
        @(posedge clk);
        cpu <= b;
        @(posedge clk);
        cpu <= bus_idle();
    endtask

    task automatic tbl_read(input logic [OBJ_AW-1:0] addr, output obj_word_t data);
        @(posedge clk);
        tbl_addr <= addr;
        @(posedge clk);
        @(negedge clk);
        data = tbl_dout;
    endtask

    // First mismatch of a test gives its one report line
    task automatic check_word(input int addr, input obj_word_t expected, input obj_word_t actual);
        assert (actual === expected) else begin
            if (!test_bad) begin
                $display("Mismatch %s at address %0d: expected %h, actual %h",
                         cur_name, addr, expected, actual);
            end
            test_bad = 1'b1;
        end
    endtask

    // Same report for counts and timing fields
    task automatic check_count(input string what, input int expected, input int actual);
        assert (actual == expected) else begin
            if (!test_bad) begin
                $display("Mismatch %s %s: expected %0d, actual %0d",
                         cur_name, what, expected, actual);
            end
            test_bad = 1'b1;
        end
    endtask

    // Counts vload pulses, sampled mid-cycle
    task automatic count_vloads(input int count, input int limit);
        int seen;
        seen = 0;
        for (int n = 0; n < limit && seen < count; n++) begin
            @(negedge clk);
            if (vid.vload) seen++;
        end
        assert (seen == count) else begin
            $display("Test %s timed out waiting for the vertical reload pulse", cur_name);
            test_bad = 1'b1;
        end
    endtask

    task automatic wait_vload();
        count_vloads(1, 2 * FRAME_CLKS);
    endtask

    // Start and end of one copy both fall on vload
    task automatic wait_sweep();
        count_vloads(2, 3 * FRAME_CLKS);
    endtask

    // One frame from vload to vload, each timing field counted
    task automatic measure_frame();
        int clks;
        int pixels;
        int visible;
        int line_starts;
        bit found;
        clks        = 0;
        pixels      = 0;
        visible     = 0;
        line_starts = 0;
        found       = 1'b0;
        wait_vload();
        check_count("vload pixel", 0, int'(vid.hdump));
        check_count("visible at vload", 0, int'(vid.lvbl));
        for (int n = 0; n < 2 * FRAME_CLKS && !found; n++) begin
            @(negedge clk);
            clks++;
            if (vid.pxl_cen) pixels++;
            if (vid.lvbl) visible++;
            if (vid.hinit) line_starts++;
            if (vid.vload) found = 1'b1;
        end
        assert (found) else begin
            if (!test_bad) begin
                $display("Test %s timed out waiting for the vertical reload pulse",
                         cur_name);
            end
            test_bad = 1'b1;
        end
        check_count("frame clocks", FRAME_CLKS, clks);
        check_count("pixel enables", V_TOTAL * H_TOTAL, pixels);
        check_count("visible clocks", V_ACTIVE * H_TOTAL * PXL_DIV, visible);
        check_count("line starts", V_TOTAL, line_starts);
    endtask

    task automatic fill_buffer(input fill_t fill, input obj_word_t value);
        obj_word_t data;
        for (int a = 0; a < OBJ_DEPTH; a++) begin
            data = (fill == FILL_RANDOM) ? obj_word_t'($urandom) : value;
            cpu_write(a[OBJ_AW-1:0], data, 2'b00);
        end
    endtask

    task automatic check_table();
        obj_word_t got;
        for (int a = 0; a < OBJ_DEPTH; a++) begin
            tbl_read(a[OBJ_AW-1:0], got);
            check_word(a, tbl_model[a], got);
        end
    endtask

    task automatic run_readback(input test_row_t row);
        logic [OBJ_AW-1:0] addr;
        obj_word_t         got;
        repeat (16) begin
            addr = OBJ_AW'($urandom);
            cpu_write(addr, obj_word_t'($urandom), row.dsn);
            cpu_read(addr, got);
            check_word(int'(addr), buf_model[addr], got);
        end
    endtask

    // Full word first, then one lane only
    task automatic run_bytes(input test_row_t row);
        logic [OBJ_AW-1:0] addr;
        obj_word_t         got;
        addr = OBJ_AW'($urandom);
        cpu_write(addr, obj_word_t'($urandom), 2'b00);
        cpu_write(addr, obj_word_t'($urandom), row.dsn);
        cpu_read(addr, got);
        check_word(int'(addr), buf_model[addr], got);
    endtask

    task automatic run_copy(input test_row_t row);
        obj_word_t value;
        obj_word_t ctrl;
        logic [7:0] group;
        value = obj_word_t'($urandom);
        fill_buffer(row.fill, value);
        ctrl = '0;
        ctrl[REG_COPY_BIT] = 1'b1;
        ctrl[REG_MODE_BIT] = row.mode;
        reg_write(ctrl);
        if (row.mode) begin
            // Only the four words of group K take the value
            group = value[7:0];
            for (int i = 0; i < 4; i++) begin
                tbl_model[{group, i[1:0]}] = value;
            end
        end else begin
            for (int a = 0; a < OBJ_DEPTH; a++) begin
                tbl_model[a] = buf_model[a];
            end
        end
        wait_sweep();
        check_table();
    endtask

    initial begin
        void'($urandom(25));
        rst       = 1'b1;
        cpu       = bus_idle();
        tbl_addr  = '0;
        tests_run = 0;
        tests_failed = 0;
        for (int a = 0; a < OBJ_DEPTH; a++) begin
            buf_model[a] = '0;
            tbl_model[a] = '0;
        end

        add_test("frame_timing", RULE_TIMING, 1'b0, FILL_NONE, 2'b00);
        add_test("cpu_readback", RULE_READBACK, 1'b0, FILL_NONE, 2'b00);
        add_test("low_byte_only", RULE_BYTES, 1'b0, FILL_NONE, 2'b10);
        add_test("high_byte_only", RULE_BYTES, 1'b0, FILL_NONE, 2'b01);
        add_test("no_copy_request", RULE_NO_COPY, 1'b0, FILL_NONE, 2'b00);
        add_test("copy_mode0", RULE_COPY_SCAN, 1'b0, FILL_RANDOM, 2'b00);
        add_test("copy_mode1", RULE_COPY_GROUP, 1'b1, FILL_SAME, 2'b00);
        add_test("one_copy_per_request", RULE_ONE_COPY, 1'b0, FILL_RANDOM, 2'b00);

        repeat (3) @(posedge clk);
        rst <= 1'b0;

        foreach (test_rows[t]) begin
            cur_name = test_names[t];
            test_bad = 1'b0;
            tests_run++;
            case (test_rows[t].rule)
                RULE_TIMING:   measure_frame();
                RULE_READBACK: run_readback(test_rows[t]);
                RULE_BYTES:    run_bytes(test_rows[t]);
                RULE_NO_COPY: begin
                    wait_vload();
                    wait_sweep();
                    check_table();
                end
                RULE_ONE_COPY: begin
                    // New buffer data, no request
                    fill_buffer(test_rows[t].fill, '0);
                    wait_sweep();
                    check_table();
                end
                default:       run_copy(test_rows[t]);
            endcase
            if (test_bad) begin
                tests_failed++;
            end else begin
                $display("Passed %s", cur_name);
            end
        end

        $display("Tests run %0d, passed %0d, failed %0d",
                 tests_run, tests_run - tests_failed, tests_failed);
        if (tests_failed == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: rtl/obj_sub_top.sv
/* Object subsystem top level
   Video timing, copy control register and object table buffer */
module obj_sub_top (
    input  logic                      clk,
    input  logic                      rst,
    // CPU bus
    input  obj_pkg::cpu_bus_t         cpu,
    output obj_pkg::obj_word_t        obj_dout,
    // Object engine table port
    input  logic [obj_pkg::OBJ_AW-1:0] tbl_addr,
    output obj_pkg::obj_word_t        tbl_dout,
    // Frame timing, also used inside
    output vid_pkg::vid_t             vid
);

    // Copy control between register and buffer
    logic obj_copy;
    logic mixpsel;

    // Pixel and line timing
    vid_timing u_timing (
        .clk (clk),
        .rst (rst),
        .vid (vid)
    );

    // Copy request and mode register
    obj_dma_regs u_regs (
        .clk      (clk),
        .rst      (rst),
        .cpu      (cpu),
        .obj_copy (obj_copy),
        .mixpsel  (mixpsel)
    );

    // Object RAM and table copy
    obj_buffer u_buffer (
        .clk      (clk),
        .rst      (rst),
        .vid      (vid),
        .cpu      (cpu),
        .obj_dout (obj_dout),
        .tbl_addr (tbl_addr),
        .tbl_dout (tbl_dout),
        .obj_copy (obj_copy),
        .mixpsel  (mixpsel)
    );

endmodule

// File: rtl/obj_buffer.sv
/* Object table buffer
   CPU object RAM copied into the engine table RAM during vertical blank */
module obj_buffer (
    input  logic                      clk,
    input  logic                      rst,
    input  vid_pkg::vid_t             vid,
    // CPU side
    input  obj_pkg::cpu_bus_t         cpu,
    output obj_pkg::obj_word_t        obj_dout,
    // Object engine side
    input  logic [obj_pkg::OBJ_AW-1:0] tbl_addr,
    output obj_pkg::obj_word_t        tbl_dout,
    // Copy control
    input  logic                      obj_copy,
    input  logic                      mixpsel
);
    import obj_pkg::*;

    logic [OBJ_NB-1:0] cpu_we;
    logic [OBJ_AW-1:0] buf_scan;
    logic [OBJ_AW-1:0] copy_addr;
    logic [OBJ_AW-3:0] copy_hi;
    obj_word_t         buf_dout;
    logic [3:0]        v14;
    logic [7:0]        buf_latch;
    logic              dma_charged;
    logic              dma_on;
    logic              copy_start;

    // CPU write, per byte strobe
    assign cpu_we = ~({OBJ_NB{cpu.rnw}} | cpu.dsn) & {OBJ_NB{cpu.objram_cs}};

    // Scan walks 64 words per line, word order inside a group reversed
    assign buf_scan = {v14, vid.hdump[7:4], ~vid.hdump[3:2]};

    // Mode 1 takes the group address from the buffer data
    assign copy_hi   = mixpsel ? buf_latch : buf_scan[OBJ_AW-1:2];
    assign copy_addr = {copy_hi, ~vid.hdump[3:2]};

    // Line counter stepping 7 to 8 inside the blank but not on a reload
    assign copy_start = !vid.lvbl && vid.hinit && !vid.vload && (v14 == 4'd7)
                        && dma_charged;

    // Line counter, reloaded on vload
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            v14 <= '0;
        end else if (vid.vload) begin
            v14 <= 4'd8;
        end else if (vid.hinit && vid.pxl_cen) begin
            v14 <= v14 + 1'b1;
        end
    end

    // Copy flags
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dma_charged <= 1'b0;
            dma_on      <= 1'b0;
        end else begin
            // Armed by the request, consumed by the start
            if (copy_start) begin
                dma_charged <= 1'b0;
            end else if (obj_copy) begin
                dma_charged <= 1'b1;
            end
            // Runs until the next reload line
            if (vid.vload) begin
                dma_on <= 1'b0;
            end else if (copy_start) begin
                dma_on <= 1'b1;
            end
        end
    end

    // Low byte of the buffer word for mode 1
    always_ff @(posedge clk) begin
        if (vid.pxl_cen) begin
            buf_latch <= buf_dout[7:0];
        end
    end

    // CPU object RAM, port B feeds the copy
    obj_dual_ram u_buffer (
        .clk    (clk),
        .addr_a (cpu.addr),
        .din_a  (cpu.dout),
        .we_a   (cpu_we),
        .q_a    (obj_dout),
        .addr_b (buf_scan),
        .q_b    (buf_dout)
    );

    // Table RAM, written by the copy and read by the engine
    obj_dual_ram u_table (
        .clk    (clk),
        .addr_a (copy_addr),
        .din_a  (buf_dout),
        .we_a   ({OBJ_NB{dma_on}}),
        .q_a    (),
        .addr_b (tbl_addr),
        .q_b    (tbl_dout)
    );

endmodule

// File: rtl/obj_dma_regs.sv
/* Object copy control register
   CPU writes make the copy request pulse and set the mode level */
module obj_dma_regs (
    input  logic              clk,
    input  logic              rst,
    input  obj_pkg::cpu_bus_t cpu,
    output logic              obj_copy,
    output logic              mixpsel
);
    import obj_pkg::*;

    logic reg_wr;

    // Any write cycle to the register select
    assign reg_wr = cpu.reg_cs && !cpu.rnw;

    // Copy request, high for the clock after the write
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            obj_copy <= 1'b0;
        end else begin
            obj_copy <= reg_wr && cpu.dout[REG_COPY_BIT];
        end
    end

    // Mode bit, held until the next register write
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mixpsel <= 1'b0;
        end else if (reg_wr) begin
            mixpsel <= cpu.dout[REG_MODE_BIT];
        end
    end

endmodule

// File: rtl/vid_timing.sv
/* Video timing generator
   Pixel enable, line and frame counters, blank and vload pulses */
module vid_timing (
    input  logic          clk,
    input  logic          rst,
    output vid_pkg::vid_t vid
);
    import vid_pkg::*;

    logic [PXL_W-1:0] cen_cnt;
    logic [H_W-1:0]   hcnt;
    logic [V_W-1:0]   vcnt;
    logic             pxl_cen;
    logic             line_end;
    logic             frame_end;
    logic             pix0;

    // One enable every PXL_DIV clocks
    assign pxl_cen = cen_cnt == PXL_W'(PXL_DIV - 1);

    // Last pixel of the line, last line of the frame
    assign line_end  = pxl_cen && (hcnt == H_W'(H_TOTAL - 1));
    assign frame_end = line_end && (vcnt == V_W'(V_TOTAL - 1));

    // Pixel 0, sampled on its enable cycle
    assign pix0 = pxl_cen && (hcnt == '0);

    // Clock divider
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cen_cnt <= '0;
        end else if (pxl_cen) begin
            cen_cnt <= '0;
        end else begin
            cen_cnt <= cen_cnt + 1'b1;
        end
    end

    // Horizontal counter, steps once per pixel
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hcnt <= '0;
        end else if (line_end) begin
            hcnt <= '0;
        end else if (pxl_cen) begin
            hcnt <= hcnt + 1'b1;
        end
    end

    // Line counter
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vcnt <= '0;
        end else if (frame_end) begin
            vcnt <= '0;
        end else if (line_end) begin
            vcnt <= vcnt + 1'b1;
        end
    end

    // Status bundle
    always_comb begin
        vid.hdump   = hcnt;
        vid.hinit   = pix0;
        vid.lvbl    = vcnt < V_W'(V_ACTIVE);
        // Single enable cycle at the start of the reload line
        vid.vload   = pix0 && (vcnt == V_W'(VLOAD_LINE));
        vid.pxl_cen = pxl_cen;
    end

endmodule

// File: rtl/obj_dual_ram.sv
/* Dual-port object word RAM
   Port A reads and writes with byte enables, port B reads only */
module obj_dual_ram (
    input  logic                      clk,
    // Port A, read and write
    input  logic [obj_pkg::OBJ_AW-1:0] addr_a,
    input  obj_pkg::obj_word_t        din_a,
    input  logic [obj_pkg::OBJ_NB-1:0] we_a,
    output obj_pkg::obj_word_t        q_a,
    // Port B, read only
    input  logic [obj_pkg::OBJ_AW-1:0] addr_b,
    output obj_pkg::obj_word_t        q_b
);
    import obj_pkg::*;

    obj_word_t mem [OBJ_DEPTH];

    // Start from a cleared table
    initial begin
        for (int i = 0; i < OBJ_DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    // Port A, byte lanes written separately
    always_ff @(posedge clk) begin
        for (int b = 0; b < OBJ_NB; b++) begin
            if (we_a[b]) begin
                mem[addr_a][b*8 +: 8] <= din_a[b*8 +: 8];
            end
        end
        // Read returns the old word on a write
        q_a <= mem[addr_a];
    end

    // Port B, registered read
    always_ff @(posedge clk) begin
        q_b <= mem[addr_b];
    end

endmodule

// File: rtl/obj_pkg.sv
/* Object RAM package
   RAM sizes, CPU bus bundle and control register bits */
package obj_pkg;

    // Object RAM, 1024 words of 16 bits
    localparam int OBJ_AW    = 10;
    localparam int OBJ_DW    = 16;
    localparam int OBJ_DEPTH = 1 << OBJ_AW;

    // Byte lanes per word
    localparam int OBJ_NB = OBJ_DW / 8;

    typedef logic [OBJ_DW-1:0] obj_word_t;

    // CPU side bus as seen by the object subsystem
    typedef struct packed {
        // Word address
        logic [OBJ_AW-1:0] addr;
        // Write data
        obj_word_t         dout;
        // Byte strobes, active low, bit 1 is the upper byte
        logic [OBJ_NB-1:0] dsn;
        // High for reads
        logic              rnw;
        // Object RAM select
        logic              objram_cs;
        // Control register select
        logic              reg_cs;
    } cpu_bus_t;

    // Control register write data
    // Bit 0 requests a table copy
    localparam int REG_COPY_BIT = 0;
    // Bit 1 selects the copy mode
    localparam int REG_MODE_BIT = 1;

endpackage

// File: rtl/vid_pkg.sv
/* Video timing package
   Frame geometry constants and the timing status bundle */
package vid_pkg;

    // Horizontal geometry, one 8-bit counter wraps the line
    localparam int H_TOTAL = 256;
    localparam int H_W     = $clog2(H_TOTAL);

    // Shortened frame for simulation
    localparam int V_TOTAL = 80;
    localparam int V_W     = $clog2(V_TOTAL);

    // Visible lines, blank covers the rest
    localparam int V_ACTIVE = 40;

    // Object table reload line, first blank line
    localparam int VLOAD_LINE = 40;

    // Clocks per pixel
    localparam int PXL_DIV = 2;
    localparam int PXL_W   = $clog2(PXL_DIV);

    // Timing status seen by the object logic
    typedef struct packed {
        logic [H_W-1:0] hdump;
        // Pixel 0 of each line, on a pixel enable
        logic           hinit;
        // High on visible lines
        logic           lvbl;
        // Pixel 0 of VLOAD_LINE
        logic           vload;
        logic           pxl_cen;
    } vid_t;

endpackage
